//--- common/sifhIfs.sv
`timescale 1ns/10ps

// histogram RAM access port, used by the scan while the pipeline is idle
interface histPortIf
    import sifhTypesPkg::*;
();
    logic     readEn;
    histAddrT readAddr;
    countT    readData;
    logic     writeEn;
    histAddrT writeAddr;
    countT    writeData;

    // requester side
    modport client (
        output readEn, readAddr, writeEn, writeAddr, writeData,
        input  readData
    );

    // RAM owner side
    modport server (
        input  readEn, readAddr, writeEn, writeAddr, writeData,
        output readData
    );
endinterface

// one peak result per peakValid pulse
interface peakIf
    import sifhTypesPkg::*;
();
    logic     peakValid;
    pixelIdxT peakPixel;
    binIdxT   peakBin;
    countT    peakCount;

    modport source (output peakValid, peakPixel, peakBin, peakCount);
    modport sink   (input  peakValid, peakPixel, peakBin, peakCount);
endinterface

//--- common/sifhRegPkg.sv
`include "sifh_defs.svh"

package sifhRegPkg;

    typedef logic [`SIFH_PADDR_WIDTH-1:0] apbAddrT;
    typedef logic [31:0] apbDataT;

    // completed frame counter in STATUS
    typedef logic [15:0] frameCountT;

    // byte offsets of the register map
    typedef enum apbAddrT {
        offCtrl   = 'h00,
        offStatus = 'h04,
        offPeak0  = 'h10,
        offPeak1  = 'h14,
        offPeak2  = 'h18,
        offPeak3  = 'h1C
    } regOffsetT;

endpackage

//--- common/sifhTypesPkg.sv
`include "sifh_defs.svh"

package sifhTypesPkg;

    // raw time of arrival from the detector
    typedef logic [`SIFH_TS_WIDTH-1:0] timestampT;

    // bin within one pixel's histogram
    typedef logic [$clog2(`SIFH_BIN_COUNT)-1:0] binIdxT;

    // pixel number
    typedef logic [$clog2(`SIFH_PIXEL_NUM)-1:0] pixelIdxT;

    // RAM address, pixel in the upper bits, bin below
    typedef logic [$bits(pixelIdxT)+$bits(binIdxT)-1:0] histAddrT;

    // one bin count, saturates at all ones
    typedef logic [`SIFH_COUNT_WIDTH-1:0] countT;

    // peak scan FSM
    typedef enum logic [2:0] {
        scanIdle,
        scanRead,
        scanCompare,
        scanStore,
        scanDone
    } scanStateT;

endpackage

//--- common/sifh_defs.svh
`ifndef SIFH_DEFS_SVH
`define SIFH_DEFS_SVH

// raw photon timestamp bits
`define SIFH_TS_WIDTH 10

// low timestamp bits dropped to form a bin
`define SIFH_BIN_SHIFT 4

// bins per pixel, must match TS width minus shift
`define SIFH_BIN_COUNT 64

// saturating bin counter width
`define SIFH_COUNT_WIDTH 8

// pixels sharing the histogram RAM
`define SIFH_PIXEL_NUM 4

// APB byte address width
`define SIFH_PADDR_WIDTH 8

`endif

//--- histUpdate/histRam.sv
`timescale 1ns/10ps
`include "sifh_defs.svh"

module histRam
    import sifhTypesPkg::*;
(
    input  logic     clk,
    input  logic     readEn,
    input  histAddrT readAddr,
    output countT    readData,
    input  logic     writeEn,
    input  histAddrT writeAddr,
    input  countT    writeData
);

    // all pixels' bins in one array
    countT mem [`SIFH_PIXEL_NUM * `SIFH_BIN_COUNT];

    // histogram starts empty at power-up
    initial begin
        for (int i = 0; i < `SIFH_PIXEL_NUM * `SIFH_BIN_COUNT; i++) begin
            mem[i] = '0;
        end
    end

    // read returns old data on a same-address collision
    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[writeAddr] <= writeData;
        end
        if (readEn) begin
            readData <= mem[readAddr];
        end
    end

endmodule

//--- histUpdate/histUpdate.sv
`timescale 1ns/10ps

module histUpdate
    import sifhTypesPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      decValid,
    input  histAddrT  decAddr,
    input  logic      decLast,
    histPortIf.server scanPort,
    output logic      frameDrained
);

    // stage 1 holds the sample whose read data is arriving
    logic     s1Valid;
    logic     s1Last;
    histAddrT s1Addr;
    // stage 2 drives the RAM write
    logic     s2Valid;
    logic     s2Last;
    histAddrT s2Addr;
    countT    s2Data;
    // write that landed on the same edge as the current read
    logic     wbValid;
    histAddrT wbAddr;
    countT    wbData;

    countT    curCount;
    countT    nextCount;
    logic     pipeBusy;

    logic     ramReadEn;
    histAddrT ramReadAddr;
    countT    ramReadData;
    logic     ramWriteEn;
    histAddrT ramWriteAddr;
    countT    ramWriteData;

    // newest value wins, the RAM copy may be one or two writes stale
    always_comb begin
        if (s2Valid && s2Addr == s1Addr) begin
            curCount = s2Data;
        end else if (wbValid && wbAddr == s1Addr) begin
            curCount = wbData;
        end else begin
            curCount = ramReadData;
        end
    end

    // saturating increment
    assign nextCount = (curCount == '1) ? curCount : curCount + 1'b1;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Valid      <= 1'b0;
            s1Last       <= 1'b0;
            s2Valid      <= 1'b0;
            s2Last       <= 1'b0;
            wbValid      <= 1'b0;
            frameDrained <= 1'b0;
        end else begin
            s1Valid      <= decValid;
            s1Last       <= decLast;
            s2Valid      <= s1Valid;
            s2Last       <= s1Last;
            wbValid      <= s2Valid;
            // last sample is in the RAM by now
            frameDrained <= s2Last;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr <= decAddr;
        s2Addr <= s1Addr;
        s2Data <= nextCount;
        wbAddr <= s2Addr;
        wbData <= s2Data;
    end

    // scan only owns the RAM once the increment pipeline is empty
    assign pipeBusy     = decValid || s1Valid || s2Valid;
    assign ramReadEn    = pipeBusy ? decValid : scanPort.readEn;
    assign ramReadAddr  = pipeBusy ? decAddr  : scanPort.readAddr;
    assign ramWriteEn   = pipeBusy ? s2Valid  : scanPort.writeEn;
    assign ramWriteAddr = pipeBusy ? s2Addr   : scanPort.writeAddr;
    assign ramWriteData = pipeBusy ? s2Data   : scanPort.writeData;
    assign scanPort.readData = ramReadData;

    histRam ram (
        .clk       (clk),
        .readEn    (ramReadEn),
        .readAddr  (ramReadAddr),
        .readData  (ramReadData),
        .writeEn   (ramWriteEn),
        .writeAddr (ramWriteAddr),
        .writeData (ramWriteData)
    );

endmodule

//--- peakScan/peakScan.sv
`timescale 1ns/10ps
`include "sifh_defs.svh"

module peakScan
    import sifhTypesPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      frameDrained,
    histPortIf.client ramPort,
    peakIf.source     peakOut,
    output logic      scanBusy
);

    scanStateT state;
    pixelIdxT  pixel;
    // bin being read this cycle
    binIdxT    rdBin;
    // bin whose data is on readData
    binIdxT    cmpBin;
    logic      cmpValid;
    binIdxT    bestBin;
    countT     bestCount;
    logic      lastBin;
    logic      lastPixel;

    assign lastBin   = (rdBin == binIdxT'(`SIFH_BIN_COUNT - 1));
    assign lastPixel = (pixel == pixelIdxT'(`SIFH_PIXEL_NUM - 1));

    // one bin read per cycle while reading
    assign ramPort.readEn   = (state == scanRead);
    assign ramPort.readAddr = {pixel, rdBin};

    // zero each bin one cycle behind its read
    assign ramPort.writeEn   = cmpValid;
    assign ramPort.writeAddr = {pixel, cmpBin};
    assign ramPort.writeData = '0;

    // result is presented for exactly the store cycle
    assign peakOut.peakValid = (state == scanStore);
    assign peakOut.peakPixel = pixel;
    assign peakOut.peakBin   = bestBin;
    assign peakOut.peakCount = bestCount;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= scanIdle;
            scanBusy <= 1'b0;
            pixel    <= '0;
            rdBin    <= '0;
            cmpValid <= 1'b0;
        end else begin
            cmpValid <= (state == scanRead);
            case (state)
                scanIdle: begin
                    if (frameDrained) begin
                        state    <= scanRead;
                        scanBusy <= 1'b1;
                        pixel    <= '0;
                        rdBin    <= '0;
                    end
                end
                scanRead: begin
                    // wraps back to bin 0 for the next pixel
                    rdBin <= rdBin + 1'b1;
                    if (lastBin) begin
                        state <= scanCompare;
                    end
                end
                // last bin's data arrives here
                scanCompare: state <= scanStore;
                scanStore: begin
                    if (lastPixel) begin
                        state    <= scanDone;
                        scanBusy <= 1'b0;
                    end else begin
                        pixel <= pixel + 1'b1;
                        state <= scanRead;
                    end
                end
                scanDone: state <= scanIdle;
                default:  state <= scanIdle;
            endcase
        end
    end

    // running max, strict compare keeps the lowest bin on a tie
    always_ff @(posedge clk) begin
        cmpBin <= rdBin;
        if (state == scanIdle || state == scanStore) begin
            bestCount <= '0;
            bestBin   <= '0;
        end else if (cmpValid && ramPort.readData > bestCount) begin
            bestCount <= ramPort.readData;
            bestBin   <= cmpBin;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the histogram engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir

verilator --binary --timing -Wno-fatal --top-module sifhTb \
    --Mdir "$buildDir" -o sifhSim -f sifh.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$buildDir/sifhSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" "$logFile"; then
    echo "testbench reported failure"
    exit 1
fi
echo "no failure found in $logFile"
exit 0

//--- sifh.f
+incdir+common
common/sifhTypesPkg.sv
common/sifhRegPkg.sv
common/sifhIfs.sv
src/sampleDecode.sv
histUpdate/histRam.sv
histUpdate/histUpdate.sv
peakScan/peakScan.sv
src/apbRegs.sv
src/sifhTop.sv
testbench/sifhTb.sv

//--- src/apbRegs.sv
`timescale 1ns/10ps
`include "sifh_defs.svh"

module apbRegs
    import sifhTypesPkg::*, sifhRegPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  logic    psel,
    input  logic    penable,
    input  logic    pwrite,
    input  apbAddrT paddr,
    input  apbDataT pwdata,
    output apbDataT prdata,
    output logic    pready,
    output logic    pslverr,
    peakIf.sink     peakIn,
    input  logic    scanBusy,
    output logic    sampleEnable
);

    regOffsetT  regSel;
    logic       access;
    logic       mapped;
    logic       ctrlWrite;
    logic       busyQ;
    frameCountT frameCount;
    pixelIdxT   peakSel;
    binIdxT     peakBinR   [`SIFH_PIXEL_NUM];
    countT      peakCountR [`SIFH_PIXEL_NUM];

    assign regSel  = regOffsetT'(paddr);
    // PEAKn word index
    assign peakSel = paddr[2 +: $bits(pixelIdxT)];
    assign access  = psel && penable;

    // never waits
    assign pready = 1'b1;

    // read mux, STATUS is busy in bit 0 and frameCount in 31:16
    always_comb begin
        prdata = '0;
        mapped = 1'b1;
        case (regSel)
            offCtrl: prdata[0] = sampleEnable;
            offStatus: begin
                prdata[0]     = scanBusy;
                prdata[31:16] = frameCount;
            end
            offPeak0, offPeak1, offPeak2, offPeak3: begin
                prdata[$bits(binIdxT)-1:0] = peakBinR[peakSel];
                prdata[8 +: $bits(countT)] = peakCountR[peakSel];
            end
            default: mapped = 1'b0;
        endcase
    end

    // only CTRL is writable
    assign pslverr   = access && (!mapped || (pwrite && regSel != offCtrl));
    assign ctrlWrite = access && pwrite && regSel == offCtrl;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sampleEnable <= 1'b0;
            busyQ        <= 1'b0;
            frameCount   <= '0;
            for (int i = 0; i < `SIFH_PIXEL_NUM; i++) begin
                peakBinR[i]   <= '0;
                peakCountR[i] <= '0;
            end
        end else begin
            busyQ <= scanBusy;
            if (ctrlWrite) begin
                sampleEnable <= pwdata[0];
            end
            // frame done when busy drops
            if (busyQ && !scanBusy) begin
                frameCount <= frameCount + 1'b1;
            end
            if (peakIn.peakValid) begin
                peakBinR[peakIn.peakPixel]   <= peakIn.peakBin;
                peakCountR[peakIn.peakPixel] <= peakIn.peakCount;
            end
        end
    end

endmodule

//--- src/sampleDecode.sv
`timescale 1ns/10ps
`include "sifh_defs.svh"

module sampleDecode
    import sifhTypesPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      sampleValid,
    input  pixelIdxT  samplePixel,
    input  timestampT sampleTime,
    input  logic      sampleLast,
    output logic      sampleReady,
    input  logic      sampleEnable,
    input  logic      scanBusy,
    output logic      decValid,
    output histAddrT  decAddr,
    output logic      decLast
);

    logic   accept;
    logic   noPhoton;
    logic   framePending;
    logic   busyQ;
    binIdxT sampleBin;

    // intake only when enabled and no frame waits for or sits in the scan
    assign sampleReady = sampleEnable && !scanBusy && !framePending;
    assign accept      = sampleValid && sampleReady;

    // all ones means no photon in this window
    assign noPhoton = (sampleTime == '1);

    // coarse bin, fine bits dropped
    assign sampleBin = sampleTime[`SIFH_TS_WIDTH-1:`SIFH_BIN_SHIFT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decValid     <= 1'b0;
            decLast      <= 1'b0;
            framePending <= 1'b0;
            busyQ        <= 1'b0;
        end else begin
            // dropped samples still pass the frame marker on
            decValid <= accept && !noPhoton;
            decLast  <= accept && sampleLast;
            busyQ    <= scanBusy;
            // hold off the next frame until its scan has finished
            if (accept && sampleLast) begin
                framePending <= 1'b1;
            end else if (busyQ && !scanBusy) begin
                framePending <= 1'b0;
            end
        end
    end

    // address payload, only meaningful with decValid
    always_ff @(posedge clk) begin
        if (accept) begin
            decAddr <= {samplePixel, sampleBin};
        end
    end

endmodule

//--- src/sifhTop.sv
`timescale 1ns/10ps

module sifhTop
    import sifhTypesPkg::*, sifhRegPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    // photon sample stream
    input  logic      sampleValid,
    input  pixelIdxT  samplePixel,
    input  timestampT sampleTime,
    input  logic      sampleLast,
    output logic      sampleReady,
    // APB slave
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apbAddrT   paddr,
    input  apbDataT   pwdata,
    output apbDataT   prdata,
    output logic      pready,
    output logic      pslverr
);

    logic     sampleEnable;
    logic     scanBusy;
    logic     decValid;
    histAddrT decAddr;
    logic     decLast;
    logic     frameDrained;

    // scan access to the histogram RAM
    histPortIf histPort ();
    // per-pixel peak results into the register file
    peakIf     peakBus ();

    sampleDecode decode (
        .clk          (clk),
        .arstN        (arstN),
        .sampleValid  (sampleValid),
        .samplePixel  (samplePixel),
        .sampleTime   (sampleTime),
        .sampleLast   (sampleLast),
        .sampleReady  (sampleReady),
        .sampleEnable (sampleEnable),
        .scanBusy     (scanBusy),
        .decValid     (decValid),
        .decAddr      (decAddr),
        .decLast      (decLast)
    );

    histUpdate execute (
        .clk          (clk),
        .arstN        (arstN),
        .decValid     (decValid),
        .decAddr      (decAddr),
        .decLast      (decLast),
        .scanPort     (histPort.server),
        .frameDrained (frameDrained)
    );

    peakScan scan (
        .clk          (clk),
        .arstN        (arstN),
        .frameDrained (frameDrained),
        .ramPort      (histPort.client),
        .peakOut      (peakBus.source),
        .scanBusy     (scanBusy)
    );

    apbRegs regs (
        .clk          (clk),
        .arstN        (arstN),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .peakIn       (peakBus.sink),
        .scanBusy     (scanBusy),
        .sampleEnable (sampleEnable)
    );

endmodule

//--- testbench/sifhTb.sv
`timescale 1ns/10ps
`include "sifh_defs.svh"

module sifhTb
    import sifhRegPkg::*;
();

    localparam int randSamples  = 400;
    localparam int emptySamples = 16;
    localparam int stimDepth    = 256;
    localparam int maxDirected  = 60;
    localparam int pixelNum     = `SIFH_PIXEL_NUM;
    localparam int binCount     = `SIFH_BIN_COUNT;
    // run is cut at twice the summed cycle estimates per phase
    localparam int sampleEst  = 2 * (maxDirected + randSamples + emptySamples);
    localparam int scanEst    = 3 * (pixelNum * (binCount + 3) + 8);
    localparam int apbEst     = 3 * 80;
    localparam int cycleLimit = 2 * (16 + sampleEst + scanEst + apbEst);

    logic                      clk = 1'b0;
    logic                      arstN;
    logic                      sampleValid;
    logic [1:0]                samplePixel;
    logic [`SIFH_TS_WIDTH-1:0] sampleTime;
    logic                      sampleLast;
    logic                      sampleReady;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [7:0]                paddr;
    logic [31:0]               pwdata;
    logic [31:0]               prdata;
    logic                      pready;
    logic                      pslverr;

    int          mismatchCount = 0;
    int          otherErrors   = 0;
    int          cycleCount    = 0;
    int          frames        = 0;
    logic [31:0] lcgState;
    // sampleReady as seen in the last APB access phase
    logic        readyAtRead;
    logic [31:0] stimMem [0:stimDepth-1];
    // reference histogram with saturating bins
    int          refHist [0:pixelNum*binCount-1];
    int          expBin   [pixelNum];
    int          expCount [pixelNum];

    sifhTop uut (
        .clk         (clk),
        .arstN       (arstN),
        .sampleValid (sampleValid),
        .samplePixel (samplePixel),
        .sampleTime  (sampleTime),
        .sampleLast  (sampleLast),
        .sampleReady (sampleReady),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    // 40 ns period
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, the run did not complete", cycleCount);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // APB setup and access phase with the result sampled on the falling edge
    task automatic apbTransfer(input logic write, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        // no wait states so the access phase completes at once
        if (pready !== 1'b1) begin
            $display("apb: pready was not high in the access phase at offset %0h", addr);
            otherErrors++;
        end
        rdata       = prdata;
        err         = pslverr;
        readyAtRead = sampleReady;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // hold the sample until ready and then log it in the reference
    task automatic sendSample(input logic [1:0] pixel, input logic [9:0] ts, input logic last);
        int idx;
        sampleValid = 1'b1;
        samplePixel = pixel;
        sampleTime  = ts;
        sampleLast  = last;
        @(negedge clk);
        while (!sampleReady) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        sampleValid = 1'b0;
        sampleLast  = 1'b0;
        // all ones is a no-photon window
        if (ts != 10'h3FF) begin
            idx = int'(pixel) * binCount + int'(ts >> `SIFH_BIN_SHIFT);
            if (refHist[idx] < 255) begin
                refHist[idx] = refHist[idx] + 1;
            end
        end
    endtask

    // poll STATUS until the scan is over and check intake stays closed while busy
    task automatic waitFrameDone(input string name, input int expFrames);
        logic [31:0] status;
        logic        err;
        logic        sawBusy;
        sawBusy = 1'b0;
        status  = '0;
        do begin
            apbTransfer(1'b0, offStatus, '0, status, err);
            if (status[0]) begin
                sawBusy = 1'b1;
                if (readyAtRead) begin
                    $display("%s: sampleReady was high while STATUS.busy was set", name);
                    otherErrors++;
                end
            end
        end while (status[0] || status[31:16] < expFrames);
        if (status[31:16] != expFrames) begin
            $display("mismatch %s frameCount: expected %0d, actual %0d",
                     name, expFrames, status[31:16]);
            mismatchCount++;
        end
        if (!sawBusy) begin
            $display("%s: STATUS.busy was never seen set during the scan", name);
            otherErrors++;
        end
    endtask

    // highest count wins and the lowest bin takes a tie
    task automatic computeRefPeaks();
        for (int p = 0; p < pixelNum; p++) begin
            expBin[p]   = 0;
            expCount[p] = 0;
            for (int b = 0; b < binCount; b++) begin
                if (refHist[p * binCount + b] > expCount[p]) begin
                    expCount[p] = refHist[p * binCount + b];
                    expBin[p]   = b;
                end
            end
        end
    endtask

    task automatic checkPeaks(input string name);
        logic [31:0] rd;
        logic        err;
        for (int p = 0; p < pixelNum; p++) begin
            apbTransfer(1'b0, 8'(int'(offPeak0) + 4 * p), '0, rd, err);
            if (err) begin
                $display("%s: read of PEAK%0d returned pslverr", name, p);
                otherErrors++;
            end
            if (rd[5:0] != expBin[p]) begin
                $display("mismatch %s PEAK%0d bin: expected %0d, actual %0d",
                         name, p, expBin[p], rd[5:0]);
                mismatchCount++;
            end
            if (rd[15:8] != expCount[p]) begin
                $display("mismatch %s PEAK%0d count: expected %0d, actual %0d",
                         name, p, expCount[p], rd[15:8]);
                mismatchCount++;
            end
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        int          nSamples;
        int          base;
        logic [1:0]  rPixel;
        logic [9:0]  rTime;
        arstN       = 1'b0;
        sampleValid = 1'b0;
        samplePixel = '0;
        sampleTime  = '0;
        sampleLast  = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        readyAtRead = 1'b0;
        lcgState    = 32'h04889218;
        for (int i = 0; i < pixelNum * binCount; i++) begin
            refHist[i] = 0;
        end
        $readmemh("testbench/sifh_stim.txt", stimMem);
        repeat (16) @(posedge clk);
        #2;
        arstN = 1'b1;

        // intake closed out of reset until CTRL is set
        if (sampleReady) begin
            $display("reset: sampleReady high with CTRL clear");
            otherErrors++;
        end
        apbTransfer(1'b0, offCtrl, '0, rd, err);
        if (rd != 32'h0) begin
            $display("mismatch reset CTRL: expected 0, actual %0h", rd);
            mismatchCount++;
        end
        if (sampleReady) begin
            $display("reset: sampleReady rose without CTRL being written");
            otherErrors++;
        end
        apbTransfer(1'b1, offCtrl, 32'h1, rd, err);
        if (err || !sampleReady) begin
            $display("enable: CTRL write failed or sampleReady did not rise");
            otherErrors++;
        end

        // directed frame from file covering forwarding and ties
        nSamples = stimMem[0];
        if (nSamples < 1 || nSamples > maxDirected) begin
            $display("directed: stim file missing or its sample count is out of range");
            otherErrors++;
        end else begin
            for (int k = 0; k < nSamples; k++) begin
                base = 1 + 3 * k;
                sendSample(stimMem[base][1:0], stimMem[base+1][9:0], stimMem[base+2][0]);
            end
            for (int p = 0; p < pixelNum; p++) begin
                base = 1 + 3 * nSamples + 3 * p;
                expBin[stimMem[base][1:0]]   = stimMem[base+1];
                expCount[stimMem[base][1:0]] = stimMem[base+2];
            end
            frames++;
            waitFrameDone("directed", frames);
            checkPeaks("directed");
        end

        // two thirds of the random samples hammer pixel 1 bin 0x11
        for (int i = 0; i < pixelNum * binCount; i++) begin
            refHist[i] = 0;
        end
        for (int i = 0; i < randSamples; i++) begin
            lcgState = lcgNext(lcgState);
            if (i % 3 != 2) begin
                rPixel = 2'd1;
                rTime  = {6'h11, lcgState[3:0]};
            end else begin
                rPixel = lcgState[17:16];
                rTime  = (i % 12 == 2) ? 10'h3FF : lcgState[9:0];
            end
            sendSample(rPixel, rTime, i == randSamples - 1);
            // occasional idle cycle from the source
            if (lcgState[31:30] == 2'b00) begin
                @(posedge clk);
                #2;
            end
        end
        frames++;
        waitFrameDone("random", frames);
        computeRefPeaks();
        checkPeaks("random");
        apbTransfer(1'b0, offPeak1, '0, rd, err);
        if (rd[15:8] != 8'd255) begin
            $display("mismatch saturation PEAK1 count: expected 255, actual %0d", rd[15:8]);
            mismatchCount++;
        end

        // frame without photons shows that every bin was cleared
        for (int i = 0; i < emptySamples; i++) begin
            sendSample(2'(i % pixelNum), 10'h3FF, i == emptySamples - 1);
        end
        frames++;
        waitFrameDone("empty", frames);
        for (int p = 0; p < pixelNum; p++) begin
            expBin[p]   = 0;
            expCount[p] = 0;
        end
        checkPeaks("empty");

        // error responses leave the registers alone
        apbTransfer(1'b1, offStatus, 32'hFFFF_FFFE, rd, err);
        if (!err) begin
            $display("slverr: write to STATUS completed without pslverr");
            otherErrors++;
        end
        apbTransfer(1'b1, offPeak0, 32'h0000_3F3F, rd, err);
        if (!err) begin
            $display("slverr: write to PEAK0 completed without pslverr");
            otherErrors++;
        end
        apbTransfer(1'b0, 8'h08, '0, rd, err);
        if (!err) begin
            $display("slverr: read of unmapped offset 0x08 completed without pslverr");
            otherErrors++;
        end
        apbTransfer(1'b0, offCtrl, '0, rd, err);
        if (err) begin
            $display("slverr: read of CTRL returned pslverr");
            otherErrors++;
        end
        if (rd != 32'h1) begin
            $display("mismatch slverr CTRL: expected 1, actual %0h", rd);
            mismatchCount++;
        end
        apbTransfer(1'b0, offStatus, '0, rd, err);
        if (rd != {16'(frames), 16'h0}) begin
            $display("mismatch slverr STATUS: expected %0h, actual %0h",
                     {16'(frames), 16'h0}, rd);
            mismatchCount++;
        end
        checkPeaks("slverr");

        $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- testbench/sifh_stim.txt
// first word: sample count; then samples as pixel timestamp last
// after the samples: expected peaks as pixel bin count
0d
0 050 0
0 055 0
0 05f 0
1 0a0 0
2 3ff 0
1 0a7 0
0 025 0
1 030 0
3 2a0 0
1 03c 0
2 3f0 0
2 3fe 0
3 3ff 1
0 05 03
1 03 02
2 3f 02
3 2a 01
